// ==== all.f ====
cpu_pkg.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_stage.sv
mem_arbiter.sv
unified_mem.sv
proc.sv
tb_proc.sv

// ==== tb_proc.sv ====
// Directed testbench for the five-stage core
// Host port tasks, program loader, ISA reference model and six tests
`timescale 1ns/1ps

module tb_proc import cpu_pkg::*; ();

   localparam word_t SENTINEL   = 16'h5A5A;
   localparam int    HALT_LIMIT = 2000;

   logic  clk;
   logic  rst_i;
   logic  dbg_req_i;
   logic  dbg_we_i;
   addr_t dbg_addr_i;
   word_t dbg_wdata_i;
   word_t dbg_rdata_o;
   logic  halt_o;
   logic  err_o;

   // Shadow of host writes, and the reference model state
   word_t image     [MEM_DEPTH];
   word_t model_mem [MEM_DEPTH];
   word_t model_reg [NUM_REGS];
   word_t prog      [$];
   int    seed;
   int    errors;
   int    tests_clean;
   int    tests_dirty;

   proc i_proc (
      .clk(clk), .rst_i(rst_i), .dbg_req_i(dbg_req_i), .dbg_we_i(dbg_we_i),
      .dbg_addr_i(dbg_addr_i), .dbg_wdata_i(dbg_wdata_i),
      .dbg_rdata_o(dbg_rdata_o), .halt_o(halt_o), .err_o(err_o));

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Register forms: ADD, SUB, AND, XOR, NOP, HALT
   function automatic word_t enc_r(input opcode_t op, input int rd, input int rs, input int rt);
      word_t w;
      w        = '0;
      w[15:12] = op;
      w[11:9]  = rd[2:0];
      w[8:6]   = rs[2:0];
      w[5:3]   = rt[2:0];
      return w;
   endfunction

   // imm6 forms: ADDI, LD, ST, BEQZ, BNEZ
   function automatic word_t enc_i(input opcode_t op, input int rd, input int rs, input int imm);
      word_t w;
      w        = '0;
      w[15:12] = op;
      w[11:9]  = rd[2:0];
      w[8:6]   = rs[2:0];
      w[5:0]   = imm[5:0];
      return w;
   endfunction

   function automatic word_t enc_j(input int imm);
      word_t w;
      w        = '0;
      w[15:12] = OP_J;
      w[11:0]  = imm[11:0];
      return w;
   endfunction

   task automatic check_word(input string name, input word_t got, input word_t exp);
      assert (got === exp) else begin
         $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_flags(input logic halt_exp, input logic err_exp);
      check_word("halt_o", {15'd0, halt_o}, {15'd0, halt_exp});
      check_word("err_o", {15'd0, err_o}, {15'd0, err_exp});
   endtask

   task automatic host_write(input addr_t a, input word_t d);
      @(posedge clk);
      dbg_req_i   <= 1'b1;
      dbg_we_i    <= 1'b1;
      dbg_addr_i  <= a;
      dbg_wdata_i <= d;
      @(posedge clk);
      dbg_req_i <= 1'b0;
      dbg_we_i  <= 1'b0;
      image[a] = d;
   endtask

   // Read data is valid in the cycle of the request
   task automatic host_read(input addr_t a, output word_t d);
      @(posedge clk);
      dbg_req_i  <= 1'b1;
      dbg_we_i   <= 1'b0;
      dbg_addr_i <= a;
      @(negedge clk);
      d = dbg_rdata_o;
      @(posedge clk);
      dbg_req_i <= 1'b0;
   endtask

   task automatic load_program();
      @(posedge clk);
      rst_i <= 1'b1;
      repeat (5) @(posedge clk);
      for (int i = 0; i < prog.size(); i++)
         host_write(i[7:0], prog[i]);
   endtask

   task automatic release_reset();
      @(posedge clk);
      rst_i <= 1'b0;
   endtask

   task automatic wait_halt();
      int cycles;
      cycles = 0;
      while (halt_o !== 1'b1 && cycles < HALT_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      assert (halt_o === 1'b1) else begin
         $display("%0t: halt_o did not rise within %0d cycles", $time, HALT_LIMIT);
         errors++;
      end
   endtask

   // Sequential ISA model, starts from the host-written image
   task automatic run_model();
      word_t    inst;
      word_t    imm6;
      word_t    imm12;
      word_t    ea;
      addr_t    pc;
      opcode_t  op;
      reg_idx_t rd;
      reg_idx_t rs;
      reg_idx_t rt;
      int       steps;
      logic     done;
      for (int i = 0; i < MEM_DEPTH; i++)
         model_mem[i] = image[i];
      for (int i = 0; i < NUM_REGS; i++)
         model_reg[i] = '0;
      pc    = '0;
      steps = 0;
      done  = 1'b0;
      while (!done && steps < 1000) begin
         inst  = model_mem[pc];
         op    = opcode_t'(inst[15:12]);
         rd    = inst[11:9];
         rs    = inst[8:6];
         rt    = inst[5:3];
         imm6  = {{10{inst[5]}}, inst[5:0]};
         imm12 = {{4{inst[11]}}, inst[11:0]};
         ea    = model_reg[rs] + imm6;
         pc    = pc + 8'd1;
         steps++;
         case (op)
            OP_ADD:  model_reg[rd] = model_reg[rs] + model_reg[rt];
            OP_SUB:  model_reg[rd] = model_reg[rs] - model_reg[rt];
            OP_AND:  model_reg[rd] = model_reg[rs] & model_reg[rt];
            OP_XOR:  model_reg[rd] = model_reg[rs] ^ model_reg[rt];
            OP_ADDI: model_reg[rd] = ea;
            OP_LD:   model_reg[rd] = model_mem[ea[7:0]];
            OP_ST:   model_mem[ea[7:0]] = model_reg[rd];
            OP_BEQZ: if (model_reg[rs] == '0) pc = pc + imm6[7:0];
            OP_BNEZ: if (model_reg[rs] != '0) pc = pc + imm6[7:0];
            OP_J:    pc = pc + imm12[7:0];
            OP_HALT: done = 1'b1;
            // NOP and illegal opcodes
            default: ;
         endcase
      end
   endtask

   task automatic run_program();
      release_reset();
      wait_halt();
      run_model();
   endtask

   task automatic check_range(input int lo, input int hi);
      word_t got;
      for (int a = lo; a <= hi; a++) begin
         host_read(a[7:0], got);
         check_word($sformatf("mem[%0d]", a), got, model_mem[a]);
      end
   endtask

   task automatic report_test(input string name, input int start);
      if (errors == start)
         tests_clean++;
      else
         tests_dirty++;
      $display("%0t: test %s finished with %0d errors", $time, name, errors - start);
   endtask

   task automatic test_host_port();
      int    start;
      int    r;
      addr_t addrs [16];
      word_t got;
      start = errors;
      prog.delete();
      prog.push_back(enc_r(OP_HALT, 0, 0, 0));
      load_program();
      release_reset();
      @(negedge clk);
      check_flags(1'b0, 1'b0);
      wait_halt();
      for (int i = 0; i < 16; i++) begin
         r = $random(seed);
         addrs[i] = r[7:0];
         r = $random(seed);
         host_write(addrs[i], r[15:0]);
      end
      // Repeated addresses compare against the last value written
      for (int i = 0; i < 16; i++) begin
         host_read(addrs[i], got);
         check_word($sformatf("dbg_rdata_o[%0d]", addrs[i]), got, image[addrs[i]]);
      end
      check_flags(1'b1, 1'b0);
      report_test("host port", start);
   endtask

   task automatic test_alu_chain();
      int start;
      start = errors;
      prog.delete();
      prog.push_back(enc_i(OP_ADDI, 7, 0, 20));
      prog.push_back(enc_r(OP_ADD, 7, 7, 7));
      prog.push_back(enc_i(OP_ADDI, 1, 0, -7));
      prog.push_back(enc_r(OP_ADD, 2, 1, 1));
      prog.push_back(enc_r(OP_SUB, 3, 2, 7));
      prog.push_back(enc_r(OP_AND, 4, 3, 1));
      prog.push_back(enc_r(OP_XOR, 5, 4, 2));
      prog.push_back(enc_r(OP_SUB, 6, 0, 5));
      for (int i = 1; i <= 6; i++)
         prog.push_back(enc_i(OP_ST, i, 7, i - 1));
      prog.push_back(enc_r(OP_HALT, 0, 0, 0));
      load_program();
      for (int a = 40; a <= 45; a++)
         host_write(a[7:0], SENTINEL);
      run_program();
      check_range(40, 45);
      check_flags(1'b1, 1'b0);
      report_test("ALU chain", start);
   endtask

   task automatic test_load_use();
      int start;
      int r;
      start = errors;
      r = $random(seed);
      prog.delete();
      prog.push_back(enc_i(OP_ADDI, 7, 0, 25));
      prog.push_back(enc_r(OP_ADD, 7, 7, 7));
      prog.push_back(enc_i(OP_ADDI, 1, 0, 19));
      prog.push_back(enc_i(OP_ADDI, 2, 0, -3));
      prog.push_back(enc_i(OP_ST, 1, 7, 0));
      prog.push_back(enc_i(OP_ST, 2, 7, 1));
      prog.push_back(enc_i(OP_LD, 3, 7, 0));
      prog.push_back(enc_i(OP_LD, 4, 7, 1));
      prog.push_back(enc_r(OP_ADD, 5, 3, 4));
      prog.push_back(enc_i(OP_ST, 5, 7, 2));
      prog.push_back(enc_i(OP_LD, 6, 7, 4));
      prog.push_back(enc_r(OP_ADD, 6, 6, 5));
      prog.push_back(enc_i(OP_ST, 6, 7, 3));
      prog.push_back(enc_r(OP_HALT, 0, 0, 0));
      load_program();
      for (int a = 50; a <= 53; a++)
         host_write(a[7:0], SENTINEL);
      host_write(8'd54, r[15:0]);
      run_program();
      check_range(50, 54);
      check_flags(1'b1, 1'b0);
      report_test("load/store", start);
   endtask

   task automatic test_branches();
      int    start;
      int    skipped [4];
      word_t got;
      start   = errors;
      skipped = '{61, 62, 64, 65};
      prog.delete();
      prog.push_back(enc_i(OP_ADDI, 7, 0, 30));
      prog.push_back(enc_r(OP_ADD, 7, 7, 7));
      prog.push_back(enc_i(OP_ADDI, 6, 0, -1));
      prog.push_back(enc_i(OP_ADDI, 1, 0, 5));
      prog.push_back(enc_i(OP_BEQZ, 0, 1, 1));
      prog.push_back(enc_i(OP_ST, 1, 7, 0));
      prog.push_back(enc_i(OP_BNEZ, 0, 1, 1));
      prog.push_back(enc_i(OP_ST, 6, 7, 1));
      prog.push_back(enc_i(OP_ADDI, 2, 0, 0));
      prog.push_back(enc_i(OP_BEQZ, 0, 2, 1));
      prog.push_back(enc_i(OP_ST, 6, 7, 2));
      prog.push_back(enc_i(OP_BNEZ, 0, 2, 1));
      prog.push_back(enc_i(OP_ST, 1, 7, 3));
      prog.push_back(enc_j(2));
      prog.push_back(enc_i(OP_ST, 6, 7, 4));
      prog.push_back(enc_i(OP_ST, 6, 7, 5));
      prog.push_back(enc_i(OP_ADDI, 3, 0, 9));
      prog.push_back(enc_i(OP_ST, 3, 7, 6));
      prog.push_back(enc_r(OP_HALT, 0, 0, 0));
      load_program();
      for (int a = 60; a <= 66; a++)
         host_write(a[7:0], SENTINEL);
      run_program();
      check_range(60, 66);
      // Marker stores on skipped paths must not have happened
      foreach (skipped[i]) begin
         host_read(skipped[i][7:0], got);
         check_word($sformatf("mem[%0d]", skipped[i]), got, SENTINEL);
      end
      check_flags(1'b1, 1'b0);
      report_test("branches", start);
   endtask

   task automatic test_contention();
      int    start;
      int    r;
      int    reads;
      word_t fixed;
      word_t got;
      start = errors;
      r     = $random(seed);
      fixed = r[15:0];
      prog.delete();
      prog.push_back(enc_i(OP_ADDI, 2, 0, 20));
      prog.push_back(enc_r(OP_ADD, 2, 2, 2));
      prog.push_back(enc_r(OP_ADD, 2, 2, 2));
      prog.push_back(enc_i(OP_ADDI, 1, 0, 12));
      prog.push_back(enc_i(OP_ST, 1, 2, 0));
      prog.push_back(enc_i(OP_ADDI, 2, 2, 1));
      prog.push_back(enc_i(OP_ADDI, 1, 1, -1));
      prog.push_back(enc_i(OP_BNEZ, 0, 1, -4));
      prog.push_back(enc_i(OP_LD, 3, 2, -1));
      prog.push_back(enc_r(OP_ADD, 4, 3, 3));
      prog.push_back(enc_i(OP_ST, 4, 2, 0));
      prog.push_back(enc_r(OP_HALT, 0, 0, 0));
      load_program();
      host_write(8'd200, fixed);
      release_reset();
      reads = 0;
      while (halt_o !== 1'b1 && reads < 200) begin
         r = $random(seed);
         repeat (r[1:0]) @(posedge clk);
         host_read(8'd200, got);
         check_word("dbg_rdata_o[200]", got, fixed);
         reads++;
      end
      wait_halt();
      run_model();
      check_range(80, 92);
      check_flags(1'b1, 1'b0);
      report_test("host contention", start);
   endtask

   task automatic test_illegal();
      int start;
      start = errors;
      prog.delete();
      prog.push_back(enc_i(OP_ADDI, 1, 0, 7));
      prog.push_back(16'hB123);
      prog.push_back(enc_i(OP_ADDI, 2, 1, 3));
      prog.push_back(enc_i(OP_ADDI, 7, 0, 31));
      prog.push_back(enc_i(OP_ST, 2, 7, 0));
      prog.push_back(enc_r(OP_XOR, 3, 2, 1));
      prog.push_back(enc_i(OP_ST, 3, 7, 1));
      prog.push_back(enc_r(OP_HALT, 0, 0, 0));
      load_program();
      host_write(8'd31, SENTINEL);
      host_write(8'd32, SENTINEL);
      run_program();
      check_range(31, 32);
      check_flags(1'b1, 1'b1);
      report_test("illegal opcode", start);
   endtask

   initial begin
      rst_i       = 1'b1;
      dbg_req_i   = 1'b0;
      dbg_we_i    = 1'b0;
      dbg_addr_i  = '0;
      dbg_wdata_i = '0;
      seed        = 85;
      errors      = 0;
      tests_clean = 0;
      tests_dirty = 0;
      for (int i = 0; i < MEM_DEPTH; i++)
         image[i] = '0;
      test_host_port();
      test_alu_chain();
      test_load_use();
      test_branches();
      test_contention();
      test_illegal();
      $display("Tests without errors: %0d, tests with errors: %0d, failed checks: %0d",
               tests_clean, tests_dirty, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== proc.sv ====
// Top level of the five-stage pipelined core
// Connects fetch, decode, register file, execute, memory stage,
// memory arbiter and the unified memory with its host debug port
`timescale 1ns/1ps

module proc import cpu_pkg::*; (
   input  logic  clk,
   input  logic  rst_i,
   input  logic  dbg_req_i,
   input  logic  dbg_we_i,
   input  addr_t dbg_addr_i,
   input  word_t dbg_wdata_i,
   output word_t dbg_rdata_o,
   output logic  halt_o,
   output logic  err_o
);

   // Fetch and IF/ID
   logic     f_req, f_gnt, if_valid;
   addr_t    f_addr, if_pc_next;
   word_t    if_inst;

   // Decode control and register file
   logic     dec_stall, redirect, fetch_freeze;
   addr_t    target;
   reg_idx_t rs_idx, rt_idx;
   word_t    rs_data, rt_data;

   // ID/EX
   alu_op_t  id_alu_op;
   word_t    id_opa, id_opb, id_store;
   reg_idx_t id_dst;
   logic     id_wr, id_ld, id_st, id_halt, id_valid;

   // EX/MEM
   word_t    ex_result, ex_store;
   reg_idx_t ex_dst;
   logic     ex_wr, ex_ld, ex_st, ex_halt, ex_valid;

   // Data access, writeback and memory port
   logic     d_req, d_we, d_gnt, mem_stall;
   addr_t    d_addr, mem_addr;
   word_t    d_wdata, mem_wdata, mem_rdata;
   logic     wb_we, halt_retired, mem_we;
   reg_idx_t wb_idx;
   word_t    wb_data;

   assign dbg_rdata_o = mem_rdata;

   fetch_stage i_fetch (
      .clk(clk), .rst_i(rst_i), .stall_i(dec_stall | mem_stall),
      .redirect_i(redirect), .freeze_i(fetch_freeze), .target_i(target),
      .gnt_i(f_gnt), .rdata_i(mem_rdata), .req_o(f_req), .addr_o(f_addr),
      .inst_o(if_inst), .pc_next_o(if_pc_next), .valid_o(if_valid));

   decode_stage i_decode (
      .clk(clk), .rst_i(rst_i), .inst_i(if_inst), .pc_next_i(if_pc_next),
      .valid_i(if_valid), .mem_stall_i(mem_stall),
      .rs_data_i(rs_data), .rt_data_i(rt_data),
      .ex_dst_i(id_dst), .mem_dst_i(ex_dst), .ex_wr_i(id_wr), .mem_wr_i(ex_wr),
      .retired_halt_i(halt_retired), .rs_idx_o(rs_idx), .rt_idx_o(rt_idx),
      .stall_o(dec_stall), .redirect_o(redirect), .freeze_o(fetch_freeze),
      .target_o(target), .alu_op_o(id_alu_op), .opa_o(id_opa), .opb_o(id_opb),
      .store_o(id_store), .dst_o(id_dst), .wr_o(id_wr), .ld_o(id_ld),
      .st_o(id_st), .halt_o(id_halt), .valid_o(id_valid),
      .halted_o(halt_o), .err_o(err_o));

   reg_file i_reg_file (
      .clk(clk), .rst_i(rst_i), .rs_idx_i(rs_idx), .rt_idx_i(rt_idx),
      .we_i(wb_we), .wr_idx_i(wb_idx), .wr_data_i(wb_data),
      .rs_data_o(rs_data), .rt_data_o(rt_data));

   execute_stage i_execute (
      .clk(clk), .rst_i(rst_i), .hold_i(mem_stall), .alu_op_i(id_alu_op),
      .opa_i(id_opa), .opb_i(id_opb), .store_i(id_store), .dst_i(id_dst),
      .wr_i(id_wr), .ld_i(id_ld), .st_i(id_st), .halt_i(id_halt),
      .valid_i(id_valid), .result_o(ex_result), .store_o(ex_store),
      .dst_o(ex_dst), .wr_o(ex_wr), .ld_o(ex_ld), .st_o(ex_st),
      .halt_o(ex_halt), .valid_o(ex_valid));

   mem_stage i_mem_stage (
      .clk(clk), .rst_i(rst_i), .result_i(ex_result), .store_i(ex_store),
      .dst_i(ex_dst), .wr_i(ex_wr), .ld_i(ex_ld), .st_i(ex_st),
      .halt_i(ex_halt), .valid_i(ex_valid), .gnt_i(d_gnt), .rdata_i(mem_rdata),
      .req_o(d_req), .we_o(d_we), .addr_o(d_addr), .wdata_o(d_wdata),
      .stall_o(mem_stall), .wb_we_o(wb_we), .wb_idx_o(wb_idx),
      .wb_data_o(wb_data), .halt_retired_o(halt_retired));

   mem_arbiter i_arbiter (
      .dbg_req_i(dbg_req_i), .dbg_we_i(dbg_we_i), .dbg_addr_i(dbg_addr_i),
      .dbg_wdata_i(dbg_wdata_i), .d_req_i(d_req), .d_we_i(d_we),
      .d_addr_i(d_addr), .d_wdata_i(d_wdata), .f_req_i(f_req),
      .f_addr_i(f_addr), .d_gnt_o(d_gnt), .f_gnt_o(f_gnt),
      .mem_we_o(mem_we), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata));

   unified_mem i_mem (
      .clk(clk), .we_i(mem_we), .addr_i(mem_addr), .wdata_i(mem_wdata),
      .rdata_o(mem_rdata));

endmodule

// ==== unified_mem.sv ====
// Unified instruction and data memory, 256 x 16
// Combinational read, write on the rising edge
`timescale 1ns/1ps

module unified_mem import cpu_pkg::*; (
   input  logic  clk,
   input  logic  we_i,
   input  addr_t addr_i,
   input  word_t wdata_i,
   output word_t rdata_o
);

   word_t mem [MEM_DEPTH];

   // Contents survive core reset so the host can preload programs
   always_ff @(posedge clk) begin
      if (we_i)
         mem[addr_i] <= wdata_i;
   end

   assign rdata_o = mem[addr_i];

endmodule

// ==== mem_arbiter.sv ====
// Fixed-priority arbiter for the unified memory
// Host debug port first, then the data stage, then fetch
`timescale 1ns/1ps

module mem_arbiter import cpu_pkg::*; (
   input  logic  dbg_req_i,
   input  logic  dbg_we_i,
   input  addr_t dbg_addr_i,
   input  word_t dbg_wdata_i,
   input  logic  d_req_i,
   input  logic  d_we_i,
   input  addr_t d_addr_i,
   input  word_t d_wdata_i,
   input  logic  f_req_i,
   input  addr_t f_addr_i,
   output logic  d_gnt_o,
   output logic  f_gnt_o,
   output logic  mem_we_o,
   output addr_t mem_addr_o,
   output word_t mem_wdata_o
);

   // Host is never refused
   assign d_gnt_o = d_req_i && !dbg_req_i;
   assign f_gnt_o = f_req_i && !dbg_req_i && !d_req_i;

   always_comb begin
      if (dbg_req_i) begin
         mem_addr_o  = dbg_addr_i;
         mem_wdata_o = dbg_wdata_i;
         mem_we_o    = dbg_we_i;
      end else if (d_req_i) begin
         mem_addr_o  = d_addr_i;
         mem_wdata_o = d_wdata_i;
         mem_we_o    = d_we_i;
      end else begin
         // Fetch only reads
         mem_addr_o  = f_addr_i;
         mem_wdata_o = '0;
         mem_we_o    = 1'b0;
      end
   end

endmodule

// ==== mem_stage.sv ====
// Memory stage
// Data memory request, stall on lost arbitration, load or ALU result
// select and the MEM/WB register that drives writeback
`timescale 1ns/1ps

module mem_stage import cpu_pkg::*; (
   input  logic     clk,
   input  logic     rst_i,
   input  word_t    result_i,
   input  word_t    store_i,
   input  reg_idx_t dst_i,
   input  logic     wr_i,
   input  logic     ld_i,
   input  logic     st_i,
   input  logic     halt_i,
   input  logic     valid_i,
   input  logic     gnt_i,
   input  word_t    rdata_i,
   output logic     req_o,
   output logic     we_o,
   output addr_t    addr_o,
   output word_t    wdata_o,
   output logic     stall_o,
   output logic     wb_we_o,
   output reg_idx_t wb_idx_o,
   output word_t    wb_data_o,
   output logic     halt_retired_o
);

   assign req_o   = valid_i && (ld_i || st_i);
   assign we_o    = st_i;
   assign addr_o  = result_i[ADDR_W-1:0];
   assign wdata_o = store_i;

   // Host or nothing else may own the memory this cycle
   assign stall_o = req_o && !gnt_i;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wb_we_o        <= 1'b0;
         halt_retired_o <= 1'b0;
      end else begin
         wb_we_o        <= !stall_o && valid_i && wr_i;
         halt_retired_o <= !stall_o && valid_i && halt_i;
      end
   end

   // MEM/WB payload
   always_ff @(posedge clk) begin
      if (!stall_o) begin
         wb_idx_o  <= dst_i;
         wb_data_o <= ld_i ? rdata_i : result_i;
      end
   end

endmodule

// ==== execute_stage.sv ====
// Execute stage
// ALU, which also forms the LD/ST address, and the EX/MEM register
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
   input  logic     clk,
   input  logic     rst_i,
   input  logic     hold_i,
   input  alu_op_t  alu_op_i,
   input  word_t    opa_i,
   input  word_t    opb_i,
   input  word_t    store_i,
   input  reg_idx_t dst_i,
   input  logic     wr_i,
   input  logic     ld_i,
   input  logic     st_i,
   input  logic     halt_i,
   input  logic     valid_i,
   output word_t    result_o,
   output word_t    store_o,
   output reg_idx_t dst_o,
   output logic     wr_o,
   output logic     ld_o,
   output logic     st_o,
   output logic     halt_o,
   output logic     valid_o
);

   word_t alu_out;

   always_comb begin
      case (alu_op_i)
         ALU_SUB: alu_out = opa_i - opb_i;
         ALU_AND: alu_out = opa_i & opb_i;
         ALU_XOR: alu_out = opa_i ^ opb_i;
         default: alu_out = opa_i + opb_i;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         {valid_o, wr_o, ld_o, st_o, halt_o} <= '0;
      end else if (!hold_i) begin
         {valid_o, wr_o, ld_o, st_o, halt_o} <= {valid_i, wr_i, ld_i, st_i, halt_i};
      end
   end

   // EX/MEM payload
   always_ff @(posedge clk) begin
      if (!hold_i) begin
         result_o <= alu_out;
         store_o  <= store_i;
         dst_o    <= dst_i;
      end
   end

endmodule

// ==== decode_stage.sv ====
// Instruction decode stage
// Field decode, interlock against ID/EX and EX/MEM destinations,
// branch and jump resolution, halt machine, error flag and ID/EX register
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
   input  logic     clk,
   input  logic     rst_i,
   input  word_t    inst_i,
   input  addr_t    pc_next_i,
   input  logic     valid_i,
   input  logic     mem_stall_i,
   input  word_t    rs_data_i,
   input  word_t    rt_data_i,
   input  reg_idx_t ex_dst_i,
   input  reg_idx_t mem_dst_i,
   input  logic     ex_wr_i,
   input  logic     mem_wr_i,
   input  logic     retired_halt_i,
   output reg_idx_t rs_idx_o,
   output reg_idx_t rt_idx_o,
   output logic     stall_o,
   output logic     redirect_o,
   output logic     freeze_o,
   output addr_t    target_o,
   output alu_op_t  alu_op_o,
   output word_t    opa_o,
   output word_t    opb_o,
   output word_t    store_o,
   output reg_idx_t dst_o,
   output logic     wr_o,
   output logic     ld_o,
   output logic     st_o,
   output logic     halt_o,
   output logic     valid_o,
   output logic     halted_o,
   output logic     err_o
);

   opcode_t    op;
   reg_idx_t   rd_f;
   reg_idx_t   rs_f;
   reg_idx_t   rt_f;
   word_t      offset;
   alu_op_t    alu_sel;
   run_state_t state;
   logic       legal;
   logic       use_rs;
   logic       use_rt;
   logic       writes;
   logic       use_imm;
   logic       taken;
   logic       active;
   logic       advance;

   assign op   = opcode_t'(inst_i[OP_LSB +: 4]);
   assign rd_f = inst_i[RD_LSB +: REG_IDX_W];
   assign rs_f = inst_i[RS_LSB +: REG_IDX_W];
   assign rt_f = inst_i[RT_LSB +: REG_IDX_W];

   // ST reads its store data through the second port
   assign rs_idx_o = rs_f;
   assign rt_idx_o = (op == OP_ST) ? rd_f : rt_f;

   always_comb begin
      legal   = 1'b1;
      use_rs  = 1'b0;
      use_rt  = 1'b0;
      writes  = 1'b0;
      use_imm = 1'b0;
      taken   = 1'b0;
      alu_sel = ALU_ADD;
      case (op)
         OP_NOP, OP_HALT: ;
         OP_ADD:  {use_rs, use_rt, writes} = 3'b111;
         OP_SUB:  begin {use_rs, use_rt, writes} = 3'b111; alu_sel = ALU_SUB; end
         OP_AND:  begin {use_rs, use_rt, writes} = 3'b111; alu_sel = ALU_AND; end
         OP_XOR:  begin {use_rs, use_rt, writes} = 3'b111; alu_sel = ALU_XOR; end
         OP_ADDI, OP_LD: {use_rs, writes, use_imm} = 3'b111;
         OP_ST:   {use_rs, use_rt, use_imm} = 3'b111;
         OP_BEQZ: begin use_rs = 1'b1; taken = (rs_data_i == '0); end
         OP_BNEZ: begin use_rs = 1'b1; taken = (rs_data_i != '0); end
         OP_J:    taken = 1'b1;
         default: legal = 1'b0;
      endcase
   end

   assign active = valid_i && (state == RUN);

   // Interlock while a source is still in flight in EX or MEM
   assign stall_o = active &&
      ((use_rs && ((ex_wr_i && ex_dst_i == rs_f) || (mem_wr_i && mem_dst_i == rs_f))) ||
       (use_rt && ((ex_wr_i && ex_dst_i == rt_idx_o) || (mem_wr_i && mem_dst_i == rt_idx_o))));

   assign advance = active && !stall_o && !mem_stall_i;

   assign offset     = (op == OP_J) ? sext12(inst_i) : sext6(inst_i);
   assign target_o   = pc_next_i + offset[ADDR_W-1:0];
   assign redirect_o = advance && legal && taken;
   assign freeze_o   = (state != RUN) || (valid_i && op == OP_HALT);
   assign halted_o   = (state == HALTED);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state   <= RUN;
         err_o   <= 1'b0;
         valid_o <= 1'b0;
         wr_o    <= 1'b0;
         ld_o    <= 1'b0;
         st_o    <= 1'b0;
         halt_o  <= 1'b0;
      end else begin
         if (active && !legal)
            err_o <= 1'b1;
         case (state)
            RUN:     if (advance && op == OP_HALT) state <= HALTING;
            HALTING: if (retired_halt_i) state <= HALTED;
            default: state <= HALTED;
         endcase
         // ID/EX control, bubble unless the instruction moves on
         if (!mem_stall_i) begin
            valid_o <= advance;
            wr_o    <= advance && writes;
            ld_o    <= advance && op == OP_LD;
            st_o    <= advance && op == OP_ST;
            halt_o  <= advance && op == OP_HALT;
         end
      end
   end

   // ID/EX payload
   always_ff @(posedge clk) begin
      if (!mem_stall_i) begin
         alu_op_o <= alu_sel;
         opa_o    <= rs_data_i;
         opb_o    <= use_imm ? sext6(inst_i) : rt_data_i;
         store_o  <= rt_data_i;
         dst_o    <= rd_f;
      end
   end

endmodule

// ==== fetch_stage.sv ====
// Instruction fetch stage
// Program counter, fetch request and the IF/ID register
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; (
   input  logic  clk,
   input  logic  rst_i,
   input  logic  stall_i,
   input  logic  redirect_i,
   input  logic  freeze_i,
   input  addr_t target_i,
   input  logic  gnt_i,
   input  word_t rdata_i,
   output logic  req_o,
   output addr_t addr_o,
   output word_t inst_o,
   output addr_t pc_next_o,
   output logic  valid_o
);

   addr_t pc;
   addr_t pc_inc;

   assign pc_inc = pc + addr_t'(1);
   assign addr_o = pc;

   // No fetch while the pipe is held or after HALT
   assign req_o = !freeze_i && !stall_i;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         pc      <= '0;
         valid_o <= 1'b0;
      end else if (!stall_i) begin
         if (redirect_i) begin
            // Word fetched this cycle is on the wrong path
            pc      <= target_i;
            valid_o <= 1'b0;
         end else if (gnt_i) begin
            pc      <= pc_inc;
            valid_o <= 1'b1;
         end else begin
            // Lost arbitration or frozen, insert a bubble
            valid_o <= 1'b0;
         end
      end
   end

   // IF/ID payload
   always_ff @(posedge clk) begin
      if (!stall_i && gnt_i) begin
         inst_o    <= rdata_i;
         pc_next_o <= pc_inc;
      end
   end

endmodule

// ==== reg_file.sv ====
// Register file of eight 16-bit registers
// Two read ports, one write port, same-cycle write-through
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
   input  logic     clk,
   input  logic     rst_i,
   input  reg_idx_t rs_idx_i,
   input  reg_idx_t rt_idx_i,
   input  logic     we_i,
   input  reg_idx_t wr_idx_i,
   input  word_t    wr_data_i,
   output word_t    rs_data_o,
   output word_t    rt_data_o
);

   word_t regs [NUM_REGS];

   always_ff @(posedge clk) begin
      if (rst_i) begin
         for (int i = 0; i < NUM_REGS; i++)
            regs[i] <= '0;
      end else if (we_i) begin
         regs[wr_idx_i] <= wr_data_i;
      end
   end

   // Bypass the value being written back this cycle
   assign rs_data_o = (we_i && wr_idx_i == rs_idx_i) ? wr_data_i : regs[rs_idx_i];
   assign rt_data_o = (we_i && wr_idx_i == rt_idx_i) ? wr_data_i : regs[rt_idx_i];

endmodule

// ==== cpu_pkg.sv ====
// Shared definitions for the 16-bit five-stage core
// Widths, word and index types, instruction fields and sign extension
// Opcode, ALU operation and decode run-state encodings
package cpu_pkg;

   localparam int WORD_W    = 16;
   localparam int ADDR_W    = 8;
   localparam int REG_IDX_W = 3;
   localparam int MEM_DEPTH = 256;
   localparam int NUM_REGS  = 8;

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [ADDR_W-1:0]    addr_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   // Instruction field positions
   localparam int OP_LSB  = 12;
   localparam int RD_LSB  = 9;
   localparam int RS_LSB  = 6;
   localparam int RT_LSB  = 3;
   localparam int IMM6_W  = 6;
   localparam int IMM12_W = 12;

   typedef enum logic [3:0] {
      OP_NOP  = 4'd0,
      OP_ADD  = 4'd1,
      OP_SUB  = 4'd2,
      OP_AND  = 4'd3,
      OP_XOR  = 4'd4,
      OP_ADDI = 4'd5,
      OP_LD   = 4'd6,
      OP_ST   = 4'd7,
      OP_BEQZ = 4'd8,
      OP_BNEZ = 4'd9,
      OP_J    = 4'd10,
      OP_HALT = 4'd15
   } opcode_t;

   typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR} alu_op_t;

   // Fetch-freeze machine in decode
   typedef enum logic [1:0] {RUN, HALTING, HALTED} run_state_t;

   function automatic word_t sext6(input word_t inst);
      return {{(WORD_W-IMM6_W){inst[IMM6_W-1]}}, inst[IMM6_W-1:0]};
   endfunction

   function automatic word_t sext12(input word_t inst);
      return {{(WORD_W-IMM12_W){inst[IMM12_W-1]}}, inst[IMM12_W-1:0]};
   endfunction

endpackage
